//--- include/arcade_video_settings.svh
/* Arcade video output settings
   Native screen geometry, rotation direction and rotated sync timing */
`ifndef ARCADE_VIDEO_SETTINGS_SVH
`define ARCADE_VIDEO_SETTINGS_SVH

// ========================================
// Native screen geometry
// ========================================
`define ARCADE_WIDTH   16
`define ARCADE_HEIGHT  12
// Black lines above and below the portrait frame
`define ARCADE_MARGIN  2
// 0 turns clockwise, 1 counter-clockwise
`define ARCADE_CCW     0

// ========================================
// Rotated line and frame timing
// ========================================
`define ARCADE_ROT_HS_START  (`ARCADE_HEIGHT + 8)
`define ARCADE_ROT_HS_END    (`ARCADE_HEIGHT + 10)
`define ARCADE_ROT_LINE_END  (`ARCADE_HEIGHT + 17)
`define ARCADE_ROT_VS_START  10
`define ARCADE_ROT_VS_END    12

`endif

//--- verilog/arcade_video_pkg.sv
/* Arcade video types and colour helpers
   3R-3G-2B pixel word and widening of its fields to 8 bits */
package arcade_video_pkg;

	// One pixel, seen either as a raw word or as colour fields
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [2:0] r;
			logic [2:0] g;
			logic [1:0] b;
		} rgb;
	} pixel_word_t;

	// Three bits repeated from the top down to fill a byte
	function automatic logic [7:0] repeat_3bit(input logic [2:0] field);
		return {field, field, field[2:1]};
	endfunction

	function automatic logic [7:0] expand_red(input logic [2:0] field);
		return repeat_3bit(field);
	endfunction

	function automatic logic [7:0] expand_green(input logic [2:0] field);
		return repeat_3bit(field);
	endfunction

	// Two bits tile the byte evenly
	function automatic logic [7:0] expand_blue(input logic [1:0] field);
		return {field, field, field, field};
	endfunction

endpackage

//--- verilog/sync_polarity_fix.sv
/* Sync polarity detector
   Measures high and low runs and turns an active-low sync active-high */
module sync_polarity_fix (
	input  logic clk,
	input  logic rst,
	input  logic sync_in,
	output logic sync_out
);

	localparam int CNT_W = 16;

	logic             sync_s1;
	logic             sync_s2;
	logic [CNT_W-1:0] run_cnt;
	logic [CNT_W-1:0] high_len;
	logic [CNT_W-1:0] low_len;
	logic             invert;

	// Pass-through stays combinational, only the polarity is registered
	assign sync_out = sync_in ^ invert;

	always_ff @(posedge clk) begin
		if (rst) begin
			sync_s1  <= 1'b0;
			sync_s2  <= 1'b0;
			run_cnt  <= '0;
			high_len <= '0;
			low_len  <= '0;
			invert   <= 1'b0;
		end else begin
			sync_s1 <= sync_in;
			sync_s2 <= sync_s1;
			// End of a low run
			if (!sync_s2 && sync_s1)
				low_len <= run_cnt;
			// End of a high run
			if (sync_s2 && !sync_s1)
				high_len <= run_cnt;
			if (sync_s2 != sync_s1)
				run_cnt <= '0;
			else if (run_cnt != {CNT_W{1'b1}})
				run_cnt <= run_cnt + 1'b1;
			// The pulse is the shorter run
			invert <= high_len > low_len;
		end
	end

endmodule

//--- verilog/pixel_capture.sv
/* Pixel capture stage
   One-clock pixel strobe, registered pixel, fixed syncs and line-aligned vertical signals */
module pixel_capture (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          ce_pix,
	input  arcade_video_pkg::pixel_word_t rgb_in,
	input  logic                          hblank,
	input  logic                          vblank,
	input  logic                          hsync,
	input  logic                          vsync,
	output logic                          cap_ce,
	output arcade_video_pkg::pixel_word_t cap_pixel,
	output logic                          cap_hs,
	output logic                          cap_vs,
	output logic                          cap_hbl,
	output logic                          cap_vbl
);

	logic ce_prev;
	logic ce_rise;
	logic hs_fix;
	logic vs_fix;

	sync_polarity_fix i_hs_fix (
		.clk      (clk),
		.rst      (rst),
		.sync_in  (hsync),
		.sync_out (hs_fix)
	);

	sync_polarity_fix i_vs_fix (
		.clk      (clk),
		.rst      (rst),
		.sync_in  (vsync),
		.sync_out (vs_fix)
	);

	// A wide strobe counts once, at its leading edge
	assign ce_rise = ce_pix & ~ce_prev;

	// ========================================
	// Strobe, syncs and blanks
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			ce_prev <= 1'b0;
			cap_ce  <= 1'b0;
			cap_hs  <= 1'b0;
			cap_vs  <= 1'b0;
			cap_hbl <= 1'b1;
			cap_vbl <= 1'b1;
		end else begin
			ce_prev <= ce_pix;
			cap_ce  <= ce_rise;
			if (ce_rise) begin
				cap_hs <= hs_fix;
				// Vsync moves only where hsync starts
				if (!cap_hs && hs_fix)
					cap_vs <= vs_fix;
				cap_hbl <= hblank;
				// Vblank moves only where the line becomes visible
				if (cap_hbl && !hblank)
					cap_vbl <= vblank;
			end
		end
	end

	// Pixel word
	always_ff @(posedge clk) begin
		if (ce_rise)
			cap_pixel <= rgb_in;
	end

endmodule

//--- verilog/rotate_frame_buffer.sv
/* Rotating double frame buffer
   Writes native frames turned by 90 degrees, reads the other half as a portrait frame */
`include "arcade_video_settings.svh"

module rotate_frame_buffer (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          pix_ce,
	input  arcade_video_pkg::pixel_word_t pix_in,
	input  logic                          hbl_in,
	input  logic                          vbl_in,
	output arcade_video_pkg::pixel_word_t rot_pixel,
	output logic                          rot_hs,
	output logic                          rot_vs,
	output logic                          rot_hbl,
	output logic                          rot_vbl
);

	localparam int  WIDTH       = `ARCADE_WIDTH;
	localparam int  HEIGHT      = `ARCADE_HEIGHT;
	localparam int  MARGIN      = `ARCADE_MARGIN;
	localparam bit  CCW         = (`ARCADE_CCW != 0);
	localparam int  HS_START    = `ARCADE_ROT_HS_START;
	localparam int  HS_END      = `ARCADE_ROT_HS_END;
	localparam int  LINE_END    = `ARCADE_ROT_LINE_END;
	localparam int  VS_START    = `ARCADE_ROT_VS_START;
	localparam int  VS_END      = `ARCADE_ROT_VS_END;
	localparam int  FRAME_LINES = WIDTH + 2 * MARGIN;
	localparam int  BUF_SIZE    = WIDTH * HEIGHT;
	localparam int  MEM_SIZE    = 2 * BUF_SIZE;
	localparam int  AW          = $clog2(MEM_SIZE);
	localparam int  XW          = $clog2(WIDTH + 1);
	localparam int  YW          = $clog2(HEIGHT + 1);
	localparam int  XOW         = $clog2(LINE_END + 1);
	localparam int  YOW         = $clog2(FRAME_LINES + 1);
	localparam int  VBW         = $clog2(VS_END + 2);

	localparam logic [AW-1:0] H_STEP  = AW'(HEIGHT);
	localparam logic [AW-1:0] BUF_A   = AW'(BUF_SIZE);
	// First address of native line 0 in each half
	localparam logic [AW-1:0] ROW0_H0 = CCW ? AW'(BUF_SIZE - HEIGHT) : AW'(HEIGHT - 1);
	localparam logic [AW-1:0] ROW0_H1 = CCW ? AW'(MEM_SIZE - HEIGHT) : AW'(BUF_SIZE + HEIGHT - 1);

	logic [7:0]     mem [MEM_SIZE];
	logic [7:0]     mem_q;

	// Write side
	logic           wr_half;
	logic [AW-1:0]  wr_addr;
	logic [AW-1:0]  wr_row;
	logic [XW-1:0]  xpos;
	logic [YW-1:0]  ypos;
	logic           blank;
	logic           blank_prev;
	logic           vbl_prev;
	logic           wr_en;
	logic [AW-1:0]  next_row;

	// Read side
	logic           rd_half;
	logic [AW-1:0]  rd_addr;
	logic [XOW-1:0] xo;
	logic [YOW-1:0] yo;
	logic [VBW-1:0] vbcnt;
	logic           rd_vs;
	logic           rd_vbl;
	logic           in_rows;
	logic           in_line;
	logic           restart_ok;
	logic           ce_d;
	logic           st_data;
	logic           st_hs;
	logic           st_vs;
	logic           st_hbl;
	logic           st_vbl;

	// ========================================
	// Write side
	// ========================================
	assign blank    = hbl_in | vbl_in;
	assign wr_en    = pix_ce & ~blank & (xpos < WIDTH) & (ypos < HEIGHT);
	assign next_row = CCW ? wr_row + 1'b1 : wr_row - 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_half    <= 1'b0;
			wr_row     <= ROW0_H0;
			wr_addr    <= ROW0_H0;
			xpos       <= '0;
			ypos       <= '0;
			blank_prev <= 1'b1;
			vbl_prev   <= 1'b1;
		end else begin
			blank_prev <= blank;
			vbl_prev   <= vbl_in;
			// Along a native line the address walks one rotated line
			if (wr_en) begin
				wr_addr <= CCW ? wr_addr - H_STEP : wr_addr + H_STEP;
				xpos    <= xpos + 1'b1;
			end
			// Line done, next column of the portrait frame
			if (!blank_prev && blank) begin
				xpos    <= '0;
				wr_row  <= next_row;
				wr_addr <= next_row;
				if (ypos < HEIGHT)
					ypos <= ypos + 1'b1;
			end
			// Frame done, swap halves
			if (!vbl_prev && vbl_in) begin
				wr_half <= ~wr_half;
				wr_row  <= wr_half ? ROW0_H0 : ROW0_H1;
				wr_addr <= wr_half ? ROW0_H0 : ROW0_H1;
				xpos    <= '0;
				ypos    <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= pix_in.raw;
		mem_q <= mem[rd_addr];
	end

	// ========================================
	// Read side
	// ========================================
	assign in_rows = (yo >= MARGIN) && (yo < WIDTH + MARGIN);
	assign in_line = xo < HEIGHT;
	// New frame only after a full vsync and once the writer has moved on
	assign restart_ok = (yo >= FRAME_LINES) && (vbcnt > VS_END) && (rd_half == wr_half);

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_half <= 1'b1;
			rd_addr <= '0;
			xo      <= '0;
			yo      <= YOW'(FRAME_LINES);
			vbcnt   <= '0;
			rd_vs   <= 1'b0;
			rd_vbl  <= 1'b1;
			st_data <= 1'b0;
			st_hs   <= 1'b0;
			st_vs   <= 1'b0;
			st_hbl  <= 1'b1;
			st_vbl  <= 1'b1;
		end else if (pix_ce) begin
			st_data <= in_rows && in_line;
			st_hbl  <= !in_line;
			st_hs   <= (xo >= HS_START) && (xo < HS_END);
			st_vs   <= rd_vs;
			st_vbl  <= rd_vbl;
			if (in_rows && in_line)
				rd_addr <= rd_addr + 1'b1;
			if (xo == LINE_END) begin
				xo <= '0;
				if (yo >= FRAME_LINES) begin
					if (vbcnt <= VS_END)
						vbcnt <= vbcnt + 1'b1;
					if (vbcnt == VS_START)
						rd_vs <= 1'b1;
					if (vbcnt == VS_END)
						rd_vs <= 1'b0;
					if (restart_ok) begin
						rd_half <= ~wr_half;
						rd_addr <= wr_half ? '0 : BUF_A;
						yo      <= '0;
						vbcnt   <= '0;
						rd_vs   <= 1'b0;
						rd_vbl  <= 1'b0;
					end
				end else begin
					yo <= yo + 1'b1;
					if (yo == FRAME_LINES - 1)
						rd_vbl <= 1'b1;
				end
			end else begin
				xo <= xo + 1'b1;
			end
		end
	end

	// Output stage, one clock after the strobe once the memory word is out
	always_ff @(posedge clk) begin
		if (rst) begin
			ce_d    <= 1'b0;
			rot_hs  <= 1'b0;
			rot_vs  <= 1'b0;
			rot_hbl <= 1'b1;
			rot_vbl <= 1'b1;
		end else begin
			ce_d <= pix_ce;
			if (ce_d) begin
				rot_hs  <= st_hs;
				rot_vs  <= st_vs;
				rot_hbl <= st_hbl;
				rot_vbl <= st_vbl;
			end
		end
	end

	// Margins and line tails come out black
	always_ff @(posedge clk) begin
		if (ce_d)
			rot_pixel.raw <= st_data ? mem_q : 8'd0;
	end

endmodule

//--- verilog/arcade_video_out.sv
/* Arcade video output stage
   Captures the native stream and outputs it either directly or rotated */
module arcade_video_out (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          ce_pix,
	input  arcade_video_pkg::pixel_word_t rgb_in,
	input  logic                          hblank,
	input  logic                          vblank,
	input  logic                          hsync,
	input  logic                          vsync,
	input  logic                          no_rotate,
	output logic                          vid_ce,
	output logic [7:0]                    vid_r,
	output logic [7:0]                    vid_g,
	output logic [7:0]                    vid_b,
	output logic                          vid_hs,
	output logic                          vid_vs,
	output logic                          vid_de
);

	logic                          cap_ce;
	arcade_video_pkg::pixel_word_t cap_pixel;
	logic                          cap_hs;
	logic                          cap_vs;
	logic                          cap_hbl;
	logic                          cap_vbl;
	arcade_video_pkg::pixel_word_t rot_pixel;
	logic                          rot_hs;
	logic                          rot_vs;
	logic                          rot_hbl;
	logic                          rot_vbl;
	logic                          norot;
	arcade_video_pkg::pixel_word_t sel_pixel;

	pixel_capture i_capture (
		.clk       (clk),
		.rst       (rst),
		.ce_pix    (ce_pix),
		.rgb_in    (rgb_in),
		.hblank    (hblank),
		.vblank    (vblank),
		.hsync     (hsync),
		.vsync     (vsync),
		.cap_ce    (cap_ce),
		.cap_pixel (cap_pixel),
		.cap_hs    (cap_hs),
		.cap_vs    (cap_vs),
		.cap_hbl   (cap_hbl),
		.cap_vbl   (cap_vbl)
	);

	rotate_frame_buffer i_rotate (
		.clk       (clk),
		.rst       (rst),
		.pix_ce    (cap_ce),
		.pix_in    (cap_pixel),
		.hbl_in    (cap_hbl),
		.vbl_in    (cap_vbl),
		.rot_pixel (rot_pixel),
		.rot_hs    (rot_hs),
		.rot_vs    (rot_vs),
		.rot_hbl   (rot_hbl),
		.rot_vbl   (rot_vbl)
	);

	always_ff @(posedge clk) begin
		if (rst)
			norot <= 1'b0;
		else
			norot <= no_rotate;
	end

	// Both paths share the capture strobe
	assign vid_ce    = cap_ce;
	assign sel_pixel = norot ? cap_pixel : rot_pixel;
	assign vid_r     = arcade_video_pkg::expand_red(sel_pixel.rgb.r);
	assign vid_g     = arcade_video_pkg::expand_green(sel_pixel.rgb.g);
	assign vid_b     = arcade_video_pkg::expand_blue(sel_pixel.rgb.b);
	assign vid_hs    = norot ? cap_hs : rot_hs;
	assign vid_vs    = norot ? cap_vs : rot_vs;
	assign vid_de    = norot ? ~(cap_hbl | cap_vbl) : ~(rot_hbl | rot_vbl);

endmodule

//--- testbench/arcade_video_out_props.sv
/* Video output stage properties
   Strobe width, data-enable against blanking and syncs out of reset */
module arcade_video_out_props (
	input logic clk,
	input logic rst,
	input logic vid_ce,
	input logic vid_de,
	input logic vid_hs,
	input logic norot,
	input logic hblank
);
	timeunit 1ns;
	timeprecision 1ps;

	// ========================================
	// Strobe and blanking
	// ========================================
	ce_one_clock: assert property (@(posedge clk) disable iff (rst) vid_ce |=> !vid_ce)
		else $error("vid_ce stayed high for two clocks");

	// Direct path, the strobed pixel's hblank was taken one clock earlier
	de_in_blank: assert property (@(posedge clk) disable iff (rst)
			(norot && vid_ce && $past(hblank)) |-> !vid_de)
		else $error("vid_de high for a pixel strobed in hblank");

	// Syncs and strobe idle right after reset
	reset_idle: assert property (@(posedge clk) rst |=> (!vid_hs && !vid_ce))
		else $error("vid_hs or vid_ce high out of reset");

endmodule

bind arcade_video_out arcade_video_out_props i_props (
	.clk    (clk),
	.rst    (rst),
	.vid_ce (vid_ce),
	.vid_de (vid_de),
	.vid_hs (vid_hs),
	.norot  (norot),
	.hblank (hblank)
);

//--- testbench/arcade_video_out_tb.sv
/* Arcade video output testbench
   Drives native frames from a test table and checks the direct and rotated outputs */
`include "arcade_video_settings.svh"

module arcade_video_out_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WIDTH          = `ARCADE_WIDTH;
	localparam int HEIGHT         = `ARCADE_HEIGHT;
	localparam int MARGIN         = `ARCADE_MARGIN;
	localparam bit CCW            = (`ARCADE_CCW != 0);
	localparam int FRAME_LINES    = WIDTH + 2 * MARGIN;
	localparam int LINE_PIX       = WIDTH + 4;
	localparam int NATIVE_LINES   = HEIGHT + 3;
	localparam int FRAMES         = 10;
	localparam int CLKS_PER_FRAME = 2 * LINE_PIX * NATIVE_LINES;
	localparam int MAX_TESTS      = 64;

	typedef struct packed {
		logic       chk;
		logic       de;
		logic       hs;
		logic       vs;
		logic [7:0] pix;
	} expect_t;

	logic                          clk = 1'b0;
	logic                          rst;
	logic                          ce_pix;
	arcade_video_pkg::pixel_word_t rgb_in;
	logic                          hblank;
	logic                          vblank;
	logic                          hsync;
	logic                          vsync;
	logic                          no_rotate;
	logic                          vid_ce;
	logic [7:0]                    vid_r;
	logic [7:0]                    vid_g;
	logic [7:0]                    vid_b;
	logic                          vid_hs;
	logic                          vid_vs;
	logic                          vid_de;

	integer      seed;
	logic [7:0]  pat [HEIGHT][WIDTH];
	expect_t     exp_q [$];
	logic        t_norot [MAX_TESTS];
	logic        t_hpol [MAX_TESTS];
	logic        t_vpol [MAX_TESTS];
	logic [31:0] t_seed [MAX_TESTS];
	int          num_tests = 0;
	bit          loaded = 0;
	int          test_idx = -1;
	int          frames_done = 0;
	bit          rot_mode = 0;
	bit          any_rot = 0;
	bit          any_direct = 0;
	int          direct_checked = 0;
	int          rot_frames_checked = 0;

	// Model of the capture stage's vertical alignment
	logic model_prev_hbl = 1'b1;
	logic model_vbl = 1'b1;
	logic model_prev_hs = 1'b0;
	logic model_vs = 1'b0;

	// Rotated output tracking
	bit   frame_ok = 0;
	int   frame_test = -1;
	int   line_cnt = 0;
	int   pix_cnt = 0;
	int   hs_rises = 0;
	logic r_prev_de = 1'b0;
	logic r_prev_hs = 1'b0;
	logic r_prev_vs = 1'b0;

	arcade_video_out i_dut (.*);

	always #4 clk = ~clk;

	// Field bits repeated from the top until the byte is full
	function automatic logic [7:0] widen_field(input logic [2:0] v, input int w);
		logic [7:0] o;
		for (int k = 0; k < 8; k++)
			o[7 - k] = v[w - 1 - (k % w)];
		return o;
	endfunction

	function automatic logic [23:0] expand_rgb(input logic [7:0] p);
		return {widen_field(p[7:5], 3), widen_field(p[4:2], 3), widen_field({1'b0, p[1:0]}, 2)};
	endfunction

	task automatic report_error(input string msg);
		$display("%0t ns: %s", $time, msg);
		$display("Errors found");
		$fatal(1, "test stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (expected == actual) else begin
			$display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
			$display("Errors found");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic load_tests();
		int          fd;
		int          n;
		string       line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		fd = $fopen("testbench/arcade_video_tests.txt", "r");
		if (fd == 0)
			report_error("cannot open the test table");
		else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h", a, b, c, d);
					if (n == 4 && num_tests < MAX_TESTS) begin
						t_norot[num_tests] = a[0];
						t_hpol[num_tests]  = b[0];
						t_vpol[num_tests]  = c[0];
						t_seed[num_tests]  = d;
						num_tests++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// One pixel: a one-clock strobe followed by an idle clock
	task automatic drive_pixel(input logic [7:0] pix, input logic hbl, input logic vbl,
			input logic hs_act, input logic vs_act, input int t, input logic chk);
		expect_t e;
		@(posedge clk);
		ce_pix     <= 1'b1;
		rgb_in.raw <= pix;
		hblank     <= hbl;
		vblank     <= vbl;
		hsync      <= t_hpol[t] ? hs_act : ~hs_act;
		vsync      <= t_vpol[t] ? vs_act : ~vs_act;
		// Vertical signals follow line edges
		if (model_prev_hbl && !hbl)
			model_vbl = vbl;
		if (!model_prev_hs && hs_act)
			model_vs = vs_act;
		model_prev_hbl = hbl;
		model_prev_hs  = hs_act;
		e.chk = chk;
		e.de  = ~(hbl | model_vbl);
		e.hs  = hs_act;
		e.vs  = model_vs;
		e.pix = pix;
		exp_q.push_back(e);
		@(posedge clk);
		ce_pix <= 1'b0;
	endtask

	task automatic drive_frame(input int t, input logic chk);
		logic [7:0] p;
		for (int y = 0; y < NATIVE_LINES; y++) begin
			for (int x = 0; x < LINE_PIX; x++) begin
				p = (y < HEIGHT && x < WIDTH) ? pat[y][x] : 8'h00;
				drive_pixel(p, x >= WIDTH, y >= HEIGHT, x == WIDTH + 1 || x == WIDTH + 2,
					y == HEIGHT + 1, t, chk);
			end
		end
	endtask

	// Geometry and content of the portrait frame
	task automatic check_rotated();
		bit         ok;
		int         j;
		logic [7:0] pix;
		ok = frame_ok && (frame_test == test_idx);
		if (vid_vs && !r_prev_vs) begin
			if (ok) begin
				check_value("rotated active lines", FRAME_LINES, line_cnt);
				rot_frames_checked++;
			end
			// Both halves must hold this test's pattern
			frame_ok   = rot_mode && (frames_done >= 2);
			frame_test = test_idx;
			ok         = frame_ok;
			line_cnt   = 0;
		end
		if (vid_hs && !r_prev_hs)
			hs_rises++;
		if (vid_de && !r_prev_de) begin
			if (ok && line_cnt > 0)
				check_value("vid_hs rises per line", 1, hs_rises);
			hs_rises = 0;
			pix_cnt  = 0;
		end
		if (vid_de && ok) begin
			j = line_cnt;
			if (j >= FRAME_LINES || pix_cnt >= HEIGHT)
				report_error("rotated frame runs past its expected size");
			else begin
				if (j < MARGIN || j >= WIDTH + MARGIN)
					pix = 8'h00;
				else if (CCW)
					pix = pat[pix_cnt][WIDTH - 1 - (j - MARGIN)];
				else
					pix = pat[HEIGHT - 1 - pix_cnt][j - MARGIN];
				check_value("rotated vid_rgb", expand_rgb(pix), {vid_r, vid_g, vid_b});
			end
		end
		if (vid_de)
			pix_cnt++;
		if (!vid_de && r_prev_de) begin
			if (ok)
				check_value("rotated vid_de pixels per line", HEIGHT, pix_cnt);
			line_cnt++;
		end
		r_prev_de = vid_de;
		r_prev_hs = vid_hs;
		r_prev_vs = vid_vs;
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		expect_t cur;
		if (!rst && vid_ce) begin
			if (exp_q.size() == 0)
				report_error("output strobe without a driven pixel");
			else begin
				cur = exp_q.pop_front();
				if (cur.chk) begin
					check_value("vid_rgb", expand_rgb(cur.pix), {vid_r, vid_g, vid_b});
					check_value("vid_de", cur.de, vid_de);
					check_value("vid_hs", cur.hs, vid_hs);
					check_value("vid_vs", cur.vs, vid_vs);
					direct_checked++;
				end
			end
			check_rotated();
		end
	end

	initial begin
		wait (loaded);
		#((longint'(num_tests) * FRAMES * CLKS_PER_FRAME + 5000) * 8);
		report_error("watchdog expired before the tests finished");
	end

	initial begin
		rst        = 1'b1;
		ce_pix     = 1'b0;
		rgb_in.raw = 8'h00;
		hblank     = 1'b1;
		vblank     = 1'b1;
		hsync      = 1'b0;
		vsync      = 1'b0;
		no_rotate  = 1'b0;
		seed       = 32'he3076d23;
		load_tests();
		loaded = 1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		for (int t = 0; t < num_tests; t++) begin
			test_idx    = t;
			frames_done = 0;
			rot_mode    = !t_norot[t];
			if (rot_mode)
				any_rot = 1;
			else
				any_direct = 1;
			seed = t_seed[t];
			for (int y = 0; y < HEIGHT; y++)
				for (int x = 0; x < WIDTH; x++)
					pat[y][x] = 8'($random(seed));
			@(posedge clk);
			no_rotate <= t_norot[t];
			for (int f = 0; f < FRAMES; f++) begin
				drive_frame(t, t_norot[t] && f >= 1);
				frames_done = f + 1;
			end
		end
		repeat (8) @(posedge clk);
		if (num_tests == 0 || (any_rot && rot_frames_checked == 0) ||
				(any_direct && direct_checked == 0))
			report_error("a path was never checked");
		else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

//--- testbench/arcade_video_tests.txt
# no_rotate hsync_polarity vsync_polarity pattern_seed (hex)
# polarity 1 means active-high, 0 means active-low
1 0 0 1a2b3c4d
1 1 1 00c0ffee
0 0 0 5eed0001
0 1 0 7731a9e2
1 0 1 0badf00d
0 1 1 13572468
1 1 0 deadbeef
1 0 0 24681357
0 0 1 cafe0042
0 0 0 91e3a7b5
1 1 1 6d2f0c88
0 1 1 3c3c5a5a
1 0 1 0f1e2d3c
0 1 0 a5a5f00f
1 0 0 55aa33cc
0 0 0 12345678
1 1 0 fedcba98
0 1 1 0000beef
1 1 1 8badcafe
0 0 1 4b1d2e3f

//--- arcade_video_out.f
+incdir+include
verilog/arcade_video_pkg.sv
verilog/sync_polarity_fix.sv
verilog/pixel_capture.sv
verilog/rotate_frame_buffer.sv
verilog/arcade_video_out.sv
testbench/arcade_video_out_props.sv
testbench/arcade_video_out_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the arcade video output testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module arcade_video_out_tb \
	-f arcade_video_out.f \
	--Mdir obj_dir

./obj_dir/Varcade_video_out_tb
